//--- run.sh
#!/bin/sh
# compile and run the core_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module core_top_tb -f src.f --Mdir "$build_dir" -o core_top_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$build_dir/core_top_tb" > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TEST FAILED" "$log"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

//--- src.f
+incdir+src
src/core_pkg.sv
src/controller_connect.sv
src/input_event_arbiter.sv
src/event_credit_tx.sv
src/bridge_connect.sv
src/core_top.sv
tests/tb_clock.sv
tests/core_top_asserts.sv
tests/core_top_tb.sv

//--- src/bridge_connect.sv
`include "core_defines.svh"

module bridge_connect import core_pkg::*; (
    input  logic                      clk_74a,
    input  logic                      arst_n,
    input  bridge_req_t               bridge_req,
    input  controller_t               controllers [`CORE_NUM_CONT],
    input  credit_t                   credits,
    output logic [`CORE_NUM_CONT-1:0] event_mask,
    output logic [31:0]               rd_data
);

    logic [31:0] base;
    logic        word_ok;
    cont_idx_t   sel;
    controller_t sel_cont;
    logic [31:0] rd_word;

    // 16-byte register block plus word slot inside it
    assign base     = {bridge_req.addr[31:4], 4'h0};
    assign word_ok  = (bridge_req.addr[1:0] == 2'b00);
    assign sel      = bridge_req.addr[3:2];
    assign sel_cont = controllers[sel];

    always_comb begin
        rd_word = '0;
        if (word_ok) begin
            case (base)
                `CORE_ADDR_MASK: begin
                    if (sel == '0) begin
                        rd_word = 32'(event_mask);
                    end
                end
                `CORE_ADDR_KEY:  rd_word = {sel_cont.cont_type, 12'h000, sel_cont.keys};
                `CORE_ADDR_JOY:  rd_word = sel_cont.joy;
                `CORE_ADDR_CREDIT: begin
                    if (sel == '0) begin
                        rd_word = 32'(credits);
                    end
                end
                default:         rd_word = '0;
            endcase
        end
    end

    // read data one cycle after rd, mask written one cycle after wr
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            event_mask <= '0;
            rd_data    <= '0;
        end else begin
            if (bridge_req.wr && (bridge_req.addr == `CORE_ADDR_MASK)) begin
                event_mask <= bridge_req.wr_data[`CORE_NUM_CONT-1:0];
            end
            if (bridge_req.rd) begin
                rd_data <= rd_word;
            end
        end
    end

endmodule

//--- src/controller_connect.sv
`include "core_defines.svh"

module controller_connect import core_pkg::*; (
    input  logic        clk_74a,
    input  logic        arst_n,
    input  logic [31:0] key,
    input  joy_t        joy,
    input  trig_t       trig,
    output controller_t controller
);

    controller_t unpacked;

    // key word layout: buttons in 15:0, type in 31:28
    // bits 27:16 carry nothing
    always_comb begin
        unpacked.keys      = key[15:0];
        unpacked.cont_type = key[31:28];
        unpacked.joy       = joy;
        unpacked.trig      = trig;
    end

    // one register stage from the pins
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            controller <= '0;
        end else begin
            controller <= unpacked;
        end
    end

endmodule

//--- src/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// controller slots on the console
`define CORE_NUM_CONT        4

// event path sizing
`define CORE_EVT_FIFO_DEPTH  4
// receiver buffer entries, loaded as credits at reset
`define CORE_EVT_CREDITS     4

// bridge word offsets, key and joy take 4 bytes per controller
`define CORE_ADDR_MASK       32'h0000_0000
`define CORE_ADDR_KEY        32'h0000_0010
`define CORE_ADDR_JOY        32'h0000_0020
`define CORE_ADDR_CREDIT     32'h0000_0030

`endif

//--- src/core_pkg.sv
package core_pkg;

    //////////////////////////////////////////////////
    // plain vector types

    // dpad, face and shoulder buttons
    typedef logic [15:0] keys_t;
    // zero when nothing is plugged in
    typedef logic [3:0]  cont_type_t;
    // lstick x/y, rstick x/y, one byte each
    typedef logic [31:0] joy_t;
    // ltrig and rtrig
    typedef logic [15:0] trig_t;
    typedef logic [1:0]  cont_idx_t;
    typedef logic [2:0]  credit_t;

    //////////////////////////////////////////////////
    // grouped signals

    typedef struct packed {
        keys_t      keys;
        cont_type_t cont_type;
        joy_t       joy;
        trig_t      trig;
    } controller_t;

    typedef struct packed {
        cont_idx_t idx;
        keys_t     keys;
        joy_t      joy;
    } cont_event_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        rd;
        logic        wr;
        logic [31:0] wr_data;
    } bridge_req_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_GRANT
    } arb_state_t;

endpackage

//--- src/core_top.sv
`include "core_defines.svh"

module core_top import core_pkg::*; (
    input  logic        clk_74a,
    input  logic        arst_n,

    // raw controller words from the console
    input  logic [31:0] cont_key  [`CORE_NUM_CONT],
    input  joy_t        cont_joy  [`CORE_NUM_CONT],
    input  trig_t       cont_trig [`CORE_NUM_CONT],

    // bridge bus, synchronous to clk_74a
    input  bridge_req_t bridge_req,
    output logic [31:0] bridge_rd_data,

    // event output with credit return
    output logic        evt_valid,
    output cont_event_t evt_data,
    input  logic        evt_credit
);

    controller_t               controllers [`CORE_NUM_CONT];
    logic [`CORE_NUM_CONT-1:0] event_mask;
    logic                      fifo_not_full;
    logic                      push;
    cont_event_t               arb_evt;
    credit_t                   credits;

    //////////////////////////////////////////////////
    // controller unpack

    for (genvar i = 0; i < `CORE_NUM_CONT; i++) begin : g_con
        controller_connect con (
            .clk_74a    (clk_74a       ),
            .arst_n     (arst_n        ),
            .key        (cont_key[i]   ),
            .joy        (cont_joy[i]   ),
            .trig       (cont_trig[i]  ),
            .controller (controllers[i])
        );
    end

    //////////////////////////////////////////////////
    // event path

    input_event_arbiter arb (
        .clk_74a       (clk_74a      ),
        .arst_n        (arst_n       ),
        .controllers   (controllers  ),
        .event_mask    (event_mask   ),
        .fifo_not_full (fifo_not_full),
        .push          (push         ),
        .evt           (arb_evt      )
    );

    event_credit_tx ctx (
        .clk_74a       (clk_74a      ),
        .arst_n        (arst_n       ),
        .push          (push         ),
        .evt           (arb_evt      ),
        .fifo_not_full (fifo_not_full),
        .credits       (credits      ),
        .evt_valid     (evt_valid    ),
        .evt_data      (evt_data     ),
        .evt_credit    (evt_credit   )
    );

    // host access to mask, snapshots and credits
    bridge_connect bc (
        .clk_74a     (clk_74a       ),
        .arst_n      (arst_n        ),
        .bridge_req  (bridge_req    ),
        .controllers (controllers   ),
        .credits     (credits       ),
        .event_mask  (event_mask    ),
        .rd_data     (bridge_rd_data)
    );

endmodule

//--- src/event_credit_tx.sv
`include "core_defines.svh"

module event_credit_tx import core_pkg::*; (
    input  logic        clk_74a,
    input  logic        arst_n,
    input  logic        push,
    input  cont_event_t evt,
    output logic        fifo_not_full,
    output credit_t     credits,
    output logic        evt_valid,
    output cont_event_t evt_data,
    input  logic        evt_credit
);

    localparam int DEPTH = `CORE_EVT_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    cont_event_t      fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    //////////////////////////////////////////////////
    // event fifo

    assign fifo_not_full = (count != CNT_W'(DEPTH));
    assign wr_en         = push && fifo_not_full;

    // head goes out as soon as a credit is available
    assign evt_valid = (count != '0) && (credits != '0);
    assign rd_en     = evt_valid;
    assign evt_data  = fifo_mem[rd_ptr];

    always_ff @(posedge clk_74a) begin
        if (wr_en) begin
            fifo_mem[wr_ptr] <= evt;
        end
    end

    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // credit counter

    // one spent per transfer, one back per receiver pulse
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            credits <= credit_t'(`CORE_EVT_CREDITS);
        end else begin
            case ({rd_en, evt_credit})
                2'b10:   credits <= credits - credit_t'(1);
                2'b01:   credits <= credits + credit_t'(1);
                default: credits <= credits;
            endcase
        end
    end

endmodule

//--- src/input_event_arbiter.sv
`include "core_defines.svh"

module input_event_arbiter import core_pkg::*; (
    input  logic                      clk_74a,
    input  logic                      arst_n,
    input  controller_t               controllers [`CORE_NUM_CONT],
    input  logic [`CORE_NUM_CONT-1:0] event_mask,
    input  logic                      fifo_not_full,
    output logic                      push,
    output cont_event_t               evt
);

    keys_t                     last_keys [`CORE_NUM_CONT];
    joy_t                      last_joy  [`CORE_NUM_CONT];
    logic [`CORE_NUM_CONT-1:0] pending;
    logic                      any_pending;
    arb_state_t                state;
    cont_idx_t                 rr_ptr;
    cont_idx_t                 grant_idx;
    cont_idx_t                 next_idx;

    //////////////////////////////////////////////////
    // change detection

    // pending while the live state differs from what was last sent
    always_comb begin
        for (int i = 0; i < `CORE_NUM_CONT; i++) begin
            pending[i] = event_mask[i]
                && (controllers[i].cont_type != '0)
                && ((controllers[i].keys != last_keys[i])
                    || (controllers[i].joy != last_joy[i]));
        end
    end

    assign any_pending = |pending;

    // first pending controller at or after the pointer
    always_comb begin
        cont_idx_t cand;
        next_idx = rr_ptr;
        for (int k = `CORE_NUM_CONT - 1; k >= 0; k--) begin
            cand = rr_ptr + cont_idx_t'(k);
            if (pending[cand]) begin
                next_idx = cand;
            end
        end
    end

    //////////////////////////////////////////////////
    // grant and push

    // re-check in grant, the input may have moved back in the meantime
    assign push = (state == ARB_GRANT) && pending[grant_idx] && fifo_not_full;

    // newest state of the granted slot
    assign evt = '{
        idx:  grant_idx,
        keys: controllers[grant_idx].keys,
        joy:  controllers[grant_idx].joy
    };

    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ARB_IDLE;
            rr_ptr    <= '0;
            grant_idx <= '0;
            for (int i = 0; i < `CORE_NUM_CONT; i++) begin
                last_keys[i] <= '0;
                last_joy[i]  <= '0;
            end
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (any_pending && fifo_not_full) begin
                        grant_idx <= next_idx;
                        state     <= ARB_GRANT;
                    end
                end
                ARB_GRANT: begin
                    if (push) begin
                        last_keys[grant_idx] <= controllers[grant_idx].keys;
                        last_joy[grant_idx]  <= controllers[grant_idx].joy;
                        rr_ptr               <= grant_idx + cont_idx_t'(1);
                    end
                    state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

//--- tests/core_top_asserts.sv
`include "core_defines.svh"

module core_top_asserts import core_pkg::*; (
    input logic    clk_74a,
    input logic    arst_n,
    input logic    evt_valid,
    input logic    evt_credit,
    input credit_t credits
);

    timeunit 1ns;
    timeprecision 100ps;

    int in_flight;

    // transfers sent and not yet given back by the receiver
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + (evt_valid ? 1 : 0) - (evt_credit ? 1 : 0);
        end
    end

    // a transfer needs a receiver slot
    no_send_at_zero: assert property (
        @(posedge clk_74a) disable iff (!arst_n)
        evt_valid |-> (in_flight < `CORE_EVT_CREDITS)
    ) else $error("evt_valid high with the receiver buffer full");

    credit_bound: assert property (
        @(posedge clk_74a) disable iff (!arst_n)
        credits <= credit_t'(`CORE_EVT_CREDITS)
    ) else $error("credit count above receiver buffer size");

    valid_known: assert property (
        @(posedge clk_74a) disable iff (!arst_n) !$isunknown(evt_valid)
    ) else $error("evt_valid unknown after reset");

endmodule

bind event_credit_tx core_top_asserts asserts_inst (
    .clk_74a    (clk_74a   ),
    .arst_n     (arst_n    ),
    .evt_valid  (evt_valid ),
    .evt_credit (evt_credit),
    .credits    (credits   )
);

//--- tests/core_top_tb.sv
`include "core_defines.svh"

module core_top_tb import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD     = 4;
    localparam int DEFAULT_CYCLES = 200;
    localparam int EVENT_CYCLES   = 800;
    // withhold, resume and drain fit well inside this
    localparam int MARGIN_CYCLES  = 1500;

    logic        clk_74a;
    logic        arst_n;
    logic [31:0] cont_key  [`CORE_NUM_CONT];
    joy_t        cont_joy  [`CORE_NUM_CONT];
    trig_t       cont_trig [`CORE_NUM_CONT];
    bridge_req_t bridge_req;
    logic [31:0] bridge_rd_data;
    logic        evt_valid;
    cont_event_t evt_data;
    logic        evt_credit;

    // model state
    int          seed;
    int          cyc;
    int          outstanding;
    int          n_events;
    logic        stim_on;
    logic        withhold;
    keys_t       cur_keys  [`CORE_NUM_CONT];
    joy_t        cur_joy   [`CORE_NUM_CONT];
    cont_type_t  cur_type  [`CORE_NUM_CONT];
    logic        enabled   [`CORE_NUM_CONT];
    logic        have_last [`CORE_NUM_CONT];
    cont_event_t last_ev   [`CORE_NUM_CONT];
    // values held since the last event, per controller
    cont_event_t hist      [`CORE_NUM_CONT][$];
    // cycles at which credits go back to the DUT
    int          due_q [$];

    tb_clock clk_gen_inst (
        .clk    (clk_74a),
        .arst_n (arst_n )
    );

    core_top core_top_inst (
        .clk_74a        (clk_74a       ),
        .arst_n         (arst_n        ),
        .cont_key       (cont_key      ),
        .cont_joy       (cont_joy      ),
        .cont_trig      (cont_trig     ),
        .bridge_req     (bridge_req    ),
        .bridge_rd_data (bridge_rd_data),
        .evt_valid      (evt_valid     ),
        .evt_data       (evt_data      ),
        .evt_credit     (evt_credit    )
    );

    //////////////////////////////////////////////////
    // reporting and compares

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_keys(input string name, input keys_t exp, input keys_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_joy(input string name, input joy_t exp, input joy_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_event(input string name, input cont_event_t exp,
                               input cont_event_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_credit(input string name, input credit_t exp, input credit_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    //////////////////////////////////////////////////
    // controller model

    function automatic cont_event_t current_state(input int i);
        current_state = '{idx: cont_idx_t'(i), keys: cur_keys[i], joy: cur_joy[i]};
    endfunction

    // new random word, junk in key bits 27:16
    task automatic change_input(input int i);
        cur_keys[i]  = keys_t'($random(seed));
        cur_joy[i]   = joy_t'($random(seed));
        cont_key[i]  = {cur_type[i], 12'($random(seed)), cur_keys[i]};
        cont_joy[i]  = cur_joy[i];
        cont_trig[i] = trig_t'($random(seed));
        hist[i].push_back(current_state(i));
    endtask

    task automatic take_event(input cont_event_t ev);
        int i;
        int pos;
        i   = int'(ev.idx);
        pos = -1;
        n_events++;
        outstanding++;
        if (outstanding > `CORE_EVT_CREDITS) begin
            abort_run("more events outstanding than receiver credits");
        end
        if (!enabled[i]) begin
            abort_run($sformatf("event from controller %0d while it is disabled", i));
        end
        if (have_last[i] && (last_ev[i] == ev)) begin
            abort_run($sformatf("controller %0d sent the same state twice in a row", i));
        end
        for (int k = 0; k < hist[i].size(); k++) begin
            if ((pos < 0) && (hist[i][k] == ev)) begin
                pos = k;
            end
        end
        if (pos < 0) begin
            abort_run($sformatf("event %h holds a state controller %0d never had", ev, i));
        end
        repeat (pos) void'(hist[i].pop_front());
        last_ev[i]   = ev;
        have_last[i] = 1'b1;
        due_q.push_back(cyc + {$random(seed)} % 7);
    endtask

    // one clock: sample outputs, return credits, drive new inputs
    task automatic tick();
        @(posedge clk_74a);
        #1;
        cyc++;
        if (evt_valid) begin
            take_event(evt_data);
        end
        evt_credit = 1'b0;
        if (!withhold && (due_q.size() > 0) && (due_q[0] <= cyc)) begin
            void'(due_q.pop_front());
            evt_credit = 1'b1;
            outstanding--;
        end
        if (stim_on) begin
            for (int i = 0; i < `CORE_NUM_CONT; i++) begin
                if (($random(seed) & 3) == 0) begin
                    change_input(i);
                end
            end
        end
    endtask

    task automatic bridge_read(input logic [31:0] addr, output logic [31:0] data);
        bridge_req = '{addr: addr, rd: 1'b1, wr: 1'b0, wr_data: 32'h0};
        tick();
        data       = bridge_rd_data;
        bridge_req = '0;
    endtask

    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        bridge_req = '{addr: addr, rd: 1'b0, wr: 1'b1, wr_data: data};
        tick();
        bridge_req = '0;
    endtask

    //////////////////////////////////////////////////
    // test sequence

    initial begin : main
        logic [31:0] word;
        logic [3:0]  mask;
        int          n_before;
        int          quiet;
        seed        = 73868;
        cyc         = 0;
        outstanding = 0;
        n_events    = 0;
        stim_on     = 1'b0;
        withhold    = 1'b0;
        bridge_req  = '0;
        evt_credit  = 1'b0;
        // slot 1 unplugged
        for (int i = 0; i < `CORE_NUM_CONT; i++) begin
            cur_keys[i]  = '0;
            cur_joy[i]   = '0;
            cur_type[i]  = (i == 1) ? cont_type_t'(0) : cont_type_t'(1 + {$random(seed)} % 15);
            enabled[i]   = 1'b0;
            have_last[i] = 1'b0;
            last_ev[i]   = '0;
            cont_key[i]  = {cur_type[i], 28'h0};
            cont_joy[i]  = '0;
            cont_trig[i] = '0;
            hist[i].push_back(current_state(i));
        end
        @(posedge arst_n);

        // mask is 0 after reset, nothing may come out
        stim_on = 1'b1;
        repeat (DEFAULT_CYCLES) tick();

        stim_on = 1'b0;
        for (int i = 0; i < `CORE_NUM_CONT; i++) begin
            change_input(i);
        end
        repeat (3) tick();
        for (int i = 0; i < `CORE_NUM_CONT; i++) begin
            bridge_read(`CORE_ADDR_KEY + 32'(4 * i), word);
            check_keys("key read buttons", cur_keys[i], word[15:0]);
            check_word("key read word", {cur_type[i], 12'h000, cur_keys[i]}, word);
            bridge_read(`CORE_ADDR_JOY + 32'(4 * i), word);
            check_joy("joy read", cur_joy[i], word);
        end

        // slot 2 masked off
        mask = 4'b1011;
        bridge_write(`CORE_ADDR_MASK, {28'hFFFF_FFF, mask});
        for (int i = 0; i < `CORE_NUM_CONT; i++) begin
            enabled[i] = mask[i] && (cur_type[i] != '0);
        end
        bridge_read(`CORE_ADDR_MASK, word);
        check_word("mask read", {28'h0, mask}, word);

        stim_on = 1'b1;
        repeat (EVENT_CYCLES) tick();
        if (n_events == 0) begin
            abort_run("no events came out during random stimulus");
        end

        // hold credits back until the receiver is full
        withhold = 1'b1;
        while (outstanding < `CORE_EVT_CREDITS) tick();
        repeat (8) tick();
        bridge_read(`CORE_ADDR_CREDIT, word);
        check_credit("credits withheld", credit_t'(`CORE_EVT_CREDITS - outstanding),
                     credit_t'(word));

        n_before = n_events;
        withhold = 1'b0;
        while (n_events == n_before) tick();

        // inputs stable, wait for the event path to drain
        stim_on = 1'b0;
        quiet   = 0;
        while (quiet < 16) begin
            tick();
            if (evt_valid || (outstanding != 0) || (due_q.size() != 0)) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        for (int i = 0; i < `CORE_NUM_CONT; i++) begin
            if (enabled[i]) begin
                if (!have_last[i]) begin
                    abort_run($sformatf("controller %0d never sent an event", i));
                end
                check_event("final event", current_state(i), last_ev[i]);
            end
        end
        bridge_read(`CORE_ADDR_CREDIT, word);
        check_credit("credits drained", credit_t'(`CORE_EVT_CREDITS), credit_t'(word));

        $display("TEST OK");
        $finish;
    end

    initial begin : watchdog
        #((5 + DEFAULT_CYCLES + EVENT_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        abort_run("watchdog expired before the test finished");
    end

endmodule

//--- tests/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held for 5 rising edges, released clear of the edge
    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule
